// File: sources.f
src/obj_pkg.sv
src/obj_dispatch.sv
src/obj_draw.sv
src/obj_rom_arb.sv
src/obj_line_buf.sv
src/obj_top.sv
dv/obj_clk_gen.sv
dv/obj_rom_model.sv
dv/obj_chk.sv
dv/obj_tb.sv

// File: Bender.yml
package:
  name: obj_line_renderer

sources:
  - src/obj_pkg.sv
  - src/obj_dispatch.sv
  - src/obj_draw.sv
  - src/obj_rom_arb.sv
  - src/obj_line_buf.sv
  - src/obj_top.sv
  - target: test
    files:
      - dv/obj_clk_gen.sv
      - dv/obj_rom_model.sv
      - dv/obj_chk.sv
      - dv/obj_tb.sv

// File: dv/obj_tb.sv
// testbench top with lfsr stimulus, line buffer model, rom address and readback checks, report
`timescale 1ns/1ps

module obj_tb;
    import obj_pkg::*;

    localparam int N_SINGLE  = 8;
    localparam int N_BURST   = 2;
    localparam int BURST_LEN = 10;
    localparam int N_READ    = N_SINGLE + N_BURST + 1;
    localparam int TIMEOUT_CYCLES = 200 * (N_SINGLE + N_BURST * BURST_LEN) + 600 * N_READ + 100;

    logic                clk, rst, req, ack, idle, rom_cs, rom_ok, rd_en;
    logic [XPOS_W-1:0]   xpos, rd_addr;
    logic [OFFSET_W-1:0] offset;
    logic [BANK_W-1:0]   bank;
    logic [PRIO_W-1:0]   prio;
    logic [PAL_W-1:0]    pal;
    logic [ROM_AW-1:0]   rom_addr;
    logic [ROM_DW-1:0]   rom_data;
    logic [PIXEL_W-1:0]  rd_data;

    logic [PIXEL_W-1:0]  exp_line [LINE_LEN];   // expected buffer contents
    logic [ROM_AW-1:0]   exp_addr [$];          // rom words still to be fetched
    logic [31:0]         lfsr = 32'h1f862f71;
    int                  cycles = 0;
    int                  n_tests = 0;
    int                  n_checks = 0;
    int                  n_errors = 0;

    obj_clk_gen u_clk (.clk, .rst);

    obj_top DUT (
        .clk, .rst, .req, .ack, .xpos, .offset, .bank, .prio, .pal,
        .rom_cs, .rom_addr, .rom_ok, .rom_data, .rd_en, .rd_addr, .rd_data, .idle
    );

    obj_rom_model u_rom (.clk, .rst, .rom_cs, .rom_addr, .rom_ok, .rom_data);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);     // one step per bit
        end
        return v;
    endfunction

    function automatic logic [COLOR_W-1:0] rom_color(input logic [ROM_AW-1:0] a, input int k);
        logic [COLOR_W-1:0] c;
        c = a[3:0] + COLOR_W'(5 * k);
        if (k == 3 && a[2:0] == 3'd7) c = COLOR_END;
        else if (k == 3 && c == COLOR_END) c = 4'd14;
        return c;
    endfunction

    function automatic int total_errors();
        return n_errors + int'(DUT.u_chk.fail_cnt);
    endfunction

    // draws one sprite into exp_line where the larger value wins
    task automatic draw_model(input logic [XPOS_W-1:0] x, input logic [OFFSET_W-1:0] off,
                              input logic [BANK_W-1:0] bk, input logic [PRIO_W+PAL_W-1:0] pp);
        logic [14:0]        w;
        logic [ROM_AW-1:0]  wa;
        logic [COLOR_W-1:0] c;
        logic [PIXEL_W-1:0] v;
        w = off[14:0];  // offset msb ignored
        c = '0;
        while (c != COLOR_END) begin
            wa = {bk[1:0], bk[2], w};
            exp_addr.push_back(wa);
            for (int k = 0; k < 4; k++) begin
                c = rom_color(wa, k);
                v = {pp, c};
                if (c != COLOR_CLEAR && v > exp_line[x]) exp_line[x] = v;
                x = x + XPOS_W'(1);     // wraps at 512
            end
            w = w + 15'd1;
        end
    endtask

    task automatic send_sprite(input logic [XPOS_W-1:0] x, input logic [OFFSET_W-1:0] off,
                               input logic [BANK_W-1:0] bk, input logic [PRIO_W+PAL_W-1:0] pp);
        draw_model(x, off, bk, pp);
        xpos   <= x;
        offset <= off;
        bank   <= bk;
        {prio, pal} <= pp;
        req    <= 1'b1;
        do @(posedge clk); while (!ack);
        req <= 1'b0;
        do @(posedge clk); while (ack);
    endtask

    task automatic wait_idle();
        do @(posedge clk); while (!idle);
    endtask

    // whole line readout with rd_data two edges behind the address
    task automatic read_line();
        logic [PIXEL_W-1:0] exp;
        n_checks++;
        assert (exp_addr.size() == 0) else begin
            $display("%0d rom words of the sent sprites were never fetched", exp_addr.size());
            n_errors++;
            exp_addr.delete();
        end
        for (int a = 0; a < LINE_LEN + 2; a++) begin
            if (a >= 2) begin
                exp = exp_line[a-2];
                n_checks++;
                assert (rd_data == exp) else begin
                    $display("error: rd_data at x %03h is %03h, expected %03h",
                             a - 2, rd_data, exp);
                    n_errors++;
                end
                exp_line[a-2] = '0;     // hardware clears on read
            end
            rd_en   <= (a < LINE_LEN);
            rd_addr <= XPOS_W'(a);
            @(posedge clk);
        end
    endtask

    task automatic report_test(input string name, input int e0);
        n_tests++;
        $display("test %-6s %s, %0d errors", name,
                 (total_errors() == e0) ? "ok" : "failed", total_errors() - e0);
    endtask

    initial begin
        int                  e0;
        logic [XPOS_W-1:0]   x;
        logic [OFFSET_W-1:0] off;
        for (int i = 0; i < LINE_LEN; i++) exp_line[i] = '0;
        req     <= 1'b0;
        xpos    <= '0;
        offset  <= '0;
        bank    <= '0;
        prio    <= '0;
        pal     <= '0;
        rd_en   <= 1'b0;
        rd_addr <= '0;
        wait (!rst);
        repeat (2) @(posedge clk);  // reset value check has run
        report_test("reset", 0);

        e0 = total_errors();
        for (int i = 0; i < N_SINGLE; i++) begin
            x   = XPOS_W'(rand_bits(XPOS_W));
            off = OFFSET_W'(rand_bits(OFFSET_W));
            if (i % 3 == 1) x = {5'h1f, 4'(rand_bits(4))};  // right edge so x wraps
            if (i % 3 == 2) off[14:3] = 12'hfff;            // last words of the bank
            send_sprite(x, off, BANK_W'(rand_bits(BANK_W)), 8'(rand_bits(8)));
            wait_idle();
            read_line();
        end
        report_test("single", e0);

        // back to back sprites in a narrow window keep both engines and the arbiter busy
        e0 = total_errors();
        for (int b = 0; b < N_BURST; b++) begin
            x = XPOS_W'(rand_bits(XPOS_W));
            for (int i = 0; i < BURST_LEN; i++) begin
                send_sprite(x + XPOS_W'(rand_bits(6)), OFFSET_W'(rand_bits(OFFSET_W)),
                            BANK_W'(rand_bits(BANK_W)), 8'(rand_bits(8)));
            end
            wait_idle();
            read_line();
        end
        report_test("burst", e0);

        e0 = total_errors();
        read_line();    // model already all zero
        report_test("clear", e0);

        $display("%0d tests, %0d checks, %0d check errors, %0d assertion failures",
                 n_tests, n_checks, n_errors, DUT.u_chk.fail_cnt);
        if (total_errors() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // each word read from the rom belongs to a sprite sent so far
    always @(posedge clk) begin
        int hit;
        if (!rst && rom_cs && rom_ok) begin
            hit = -1;
            for (int i = 0; i < exp_addr.size(); i++) begin
                if (hit < 0 && exp_addr[i] == rom_addr) hit = i;
            end
            n_checks++;
            assert (hit >= 0) else begin
                $display("error: rom_addr %05h is no word of any sprite sent", rom_addr);
                n_errors++;
            end
            if (hit >= 0) exp_addr.delete(hit);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

endmodule

// File: dv/obj_chk.sv
// obj_chk: concurrent checks on reset values, descriptor handshake and rom port
`timescale 1ns/1ps

module obj_chk (
    input logic                         clk,
    input logic                         rst,
    input logic                         req,
    input logic                         ack,
    input logic                         idle,
    input logic                         rom_cs,
    input logic [obj_pkg::ROM_AW-1:0]   rom_addr,
    input logic                         rom_ok,
    input logic [obj_pkg::PIXEL_W-1:0]  rd_data
);
    int unsigned fail_cnt = 0;  // failed assertions so far

    // first cycle out of reset
    reset_values: assert property (@(posedge clk)
        $fell(rst) |-> !ack && !rom_cs && idle && rd_data == '0)
        else begin
            $error("outputs not at their reset values when reset is released");
            fail_cnt++;
        end

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> req && $past(req))
        else begin
            $error("ack rose without a pending req");
            fail_cnt++;
        end

    ack_drops_after_req: assert property (@(posedge clk) disable iff (rst)
        $fell(ack) |-> !$past(req))
        else begin
            $error("ack fell while req was still high");
            fail_cnt++;
        end

    // no back-pressure when idle
    ack_when_idle: assert property (@(posedge clk) disable iff (rst)
        $rose(req) && idle |=> ack)
        else begin
            $error("ack did not follow req by one cycle while idle");
            fail_cnt++;
        end

    rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr))
        else begin
            $error("rom cs dropped or rom address moved before ok");
            fail_cnt++;
        end

    rom_ok_in_cs: assert property (@(posedge clk) disable iff (rst)
        rom_ok |-> rom_cs)
        else begin
            $error("rom ok outside a cs transaction");
            fail_cnt++;
        end

endmodule

bind obj_top obj_chk u_chk (
    .clk(clk), .rst(rst), .req(req), .ack(ack), .idle(idle),
    .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_ok(rom_ok), .rd_data(rd_data)
);

// File: dv/obj_rom_model.sv
// obj_rom_model: graphics rom model, address-derived content, random ok latency
`timescale 1ns/1ps

module obj_rom_model (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rom_cs,
    input  logic [obj_pkg::ROM_AW-1:0]  rom_addr,
    output logic                        rom_ok,
    output logic [obj_pkg::ROM_DW-1:0]  rom_data
);
    import obj_pkg::*;

    logic [31:0] lfsr = 32'h1f862f71;
    logic [2:0]  wait_len;  // cs to ok, 1..4 cycles
    logic [2:0]  waited;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    // pixel k = low nibble of a + 5k, last pixel marks the end on a[2:0] == 7
    function automatic logic [ROM_DW-1:0] rom_word(input logic [ROM_AW-1:0] a);
        logic [COLOR_W-1:0] px;
        logic [ROM_DW-1:0]  w;
        w = '0;
        for (int k = 0; k < 4; k++) begin
            px = a[3:0] + COLOR_W'(5 * k);
            if (k == 3 && a[2:0] == 3'd7) px = COLOR_END;
            else if (k == 3 && px == COLOR_END) px = 4'd14;
            w = {w[ROM_DW-COLOR_W-1:0], px};    // first pixel ends on top
        end
        return w;
    endfunction

    // one lfsr step per latency bit
    task automatic pick_latency();
        logic [1:0] r;
        r[0] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        r[1] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        wait_len <= {1'b0, r} + 3'd1;
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_ok   <= 1'b0;
            rom_data <= '0;
            waited   <= '0;
            wait_len <= 3'd1;
        end else begin
            rom_ok <= 1'b0;     // single cycle ok
            if (rom_ok) begin
                waited <= '0;
                pick_latency();
            end else if (rom_cs) begin
                if (waited + 3'd1 == wait_len) begin
                    rom_ok   <= 1'b1;
                    rom_data <= rom_word(rom_addr);
                end
                waited <= waited + 3'd1;
            end
        end
    end

endmodule

// File: dv/obj_clk_gen.sv
// obj_clk_gen: testbench clock and power-on reset
`timescale 1ns/1ps

module obj_clk_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);  // held for 8 cycles
        rst <= 1'b0;
    end

endmodule

// File: src/obj_top.sv
// obj_top: sprite line renderer top, dispatcher, two draw engines, rom arbiter, line buffer
`timescale 1ns/1ps

module obj_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req,
    output logic                          ack,
    input  logic [obj_pkg::XPOS_W-1:0]    xpos,
    input  logic [obj_pkg::OFFSET_W-1:0]  offset,
    input  logic [obj_pkg::BANK_W-1:0]    bank,
    input  logic [obj_pkg::PRIO_W-1:0]    prio,
    input  logic [obj_pkg::PAL_W-1:0]     pal,
    output logic                          rom_cs,
    output logic [obj_pkg::ROM_AW-1:0]    rom_addr,
    input  logic                          rom_ok,
    input  logic [obj_pkg::ROM_DW-1:0]    rom_data,
    input  logic                          rd_en,
    input  logic [obj_pkg::XPOS_W-1:0]    rd_addr,
    output logic [obj_pkg::PIXEL_W-1:0]   rd_data,
    output logic                          idle
);
    import obj_pkg::*;

    // registered descriptor shared by both engines
    logic [XPOS_W-1:0]   d_xpos;
    logic [OFFSET_W-1:0] d_offset;
    logic [BANK_W-1:0]   d_bank;
    logic [PRIO_W-1:0]   d_prio;
    logic [PAL_W-1:0]    d_pal;

    logic                start0, start1, busy0, busy1;
    logic                cs0, cs1, ok0, ok1;
    logic [ROM_AW-1:0]   addr0, addr1;
    logic [ROM_DW-1:0]   data0, data1;
    logic                we0, we1;
    logic [XPOS_W-1:0]   bf_addr0, bf_addr1;
    logic [PIXEL_W-1:0]  bf_data0, bf_data1;

    obj_dispatch u_disp (
        .clk, .rst, .req, .ack, .xpos, .offset, .bank, .prio, .pal,
        .busy0, .busy1, .start0, .start1,
        .d_xpos, .d_offset, .d_bank, .d_prio, .d_pal, .idle
    );

    obj_draw u_draw0 (
        .clk, .rst, .start(start0), .busy(busy0),
        .xpos(d_xpos), .offset(d_offset), .bank(d_bank), .prio(d_prio), .pal(d_pal),
        .rom_ok(ok0), .rom_cs(cs0), .rom_addr(addr0), .rom_data(data0),
        .bf_we(we0), .bf_addr(bf_addr0), .bf_data(bf_data0)
    );

    obj_draw u_draw1 (
        .clk, .rst, .start(start1), .busy(busy1),
        .xpos(d_xpos), .offset(d_offset), .bank(d_bank), .prio(d_prio), .pal(d_pal),
        .rom_ok(ok1), .rom_cs(cs1), .rom_addr(addr1), .rom_data(data1),
        .bf_we(we1), .bf_addr(bf_addr1), .bf_data(bf_data1)
    );

    obj_rom_arb u_arb (
        .clk, .rst, .cs0, .cs1, .addr0, .addr1, .ok0, .ok1, .data0, .data1,
        .rom_cs, .rom_addr, .rom_ok, .rom_data
    );

    obj_line_buf u_buf (
        .clk, .rst, .we0, .we1, .addr0(bf_addr0), .addr1(bf_addr1),
        .data0(bf_data0), .data1(bf_data1), .rd_en, .rd_addr, .rd_data
    );

endmodule

// File: src/obj_line_buf.sv
// obj_line_buf: 512-entry line buffer, two write ports with priority merge, read-and-clear port
`timescale 1ns/1ps

module obj_line_buf (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         we0,
    input  logic                         we1,
    input  logic [obj_pkg::XPOS_W-1:0]   addr0,
    input  logic [obj_pkg::XPOS_W-1:0]   addr1,
    input  logic [obj_pkg::PIXEL_W-1:0]  data0,
    input  logic [obj_pkg::PIXEL_W-1:0]  data1,
    input  logic                         rd_en,
    input  logic [obj_pkg::XPOS_W-1:0]   rd_addr,
    output logic [obj_pkg::PIXEL_W-1:0]  rd_data
);
    import obj_pkg::*;

    logic [PIXEL_W-1:0] mem [LINE_LEN];

    logic               wr0, wr1;   // write after transparent drop
    logic               same;       // both ports hit one entry
    logic [PIXEL_W-1:0] both_max;
    logic [PIXEL_W-1:0] new0, new1;

    function automatic logic [PIXEL_W-1:0] pix_max(
        input logic [PIXEL_W-1:0] a,
        input logic [PIXEL_W-1:0] b
    );
        return (a > b) ? a : b;
    endfunction

    // colour 0 never lands
    assign wr0 = we0 && (data0[COLOR_W-1:0] != COLOR_CLEAR);
    assign wr1 = we1 && (data1[COLOR_W-1:0] != COLOR_CLEAR);
    assign same = wr0 && wr1 && (addr0 == addr1);

    assign both_max = pix_max(data0, data1);

    // larger value wins, order independent
    assign new0 = pix_max(mem[addr0], same ? both_max : data0);
    assign new1 = pix_max(mem[addr1], same ? both_max : data1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_data <= {PIXEL_W{1'b0}};
            for (int i = 0; i < LINE_LEN; i++) begin
                mem[i] <= {PIXEL_W{1'b0}};
            end
        end else begin
            if (rd_en) begin
                rd_data      <= mem[rd_addr];
                mem[rd_addr] <= {PIXEL_W{1'b0}};    // clear on read
            end
            // writes come after the clear, same address keeps the write
            if (wr0) begin
                mem[addr0] <= new0;
            end
            if (wr1) begin
                mem[addr1] <= new1;     // equals new0 when same
            end
        end
    end

endmodule

// File: src/obj_rom_arb.sv
// obj_rom_arb: round-robin grant of the shared graphics rom port to two draw engines
`timescale 1ns/1ps

module obj_rom_arb (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cs0,
    input  logic                        cs1,
    input  logic [obj_pkg::ROM_AW-1:0]  addr0,
    input  logic [obj_pkg::ROM_AW-1:0]  addr1,
    output logic                        ok0,
    output logic                        ok1,
    output logic [obj_pkg::ROM_DW-1:0]  data0,
    output logic [obj_pkg::ROM_DW-1:0]  data1,
    output logic                        rom_cs,
    output logic [obj_pkg::ROM_AW-1:0]  rom_addr,
    input  logic                        rom_ok,
    input  logic [obj_pkg::ROM_DW-1:0]  rom_data
);
    import obj_pkg::*;

    logic gnt_vld;  // a transaction is owned
    logic owner;    // 0 = engine 0, 1 = engine 1
    logic last;     // previous owner, for round robin
    logic cs_own;

    assign cs_own   = owner ? cs1 : cs0;
    assign rom_cs   = gnt_vld && cs_own;
    assign rom_addr = owner ? addr1 : addr0;

    // ok and data go to the owner only
    assign ok0   = gnt_vld && !owner && rom_ok;
    assign ok1   = gnt_vld && owner && rom_ok;
    assign data0 = ok0 ? rom_data : {ROM_DW{1'b0}};
    assign data1 = ok1 ? rom_data : {ROM_DW{1'b0}};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gnt_vld <= 1'b0;
            owner   <= 1'b0;
            last    <= 1'b1;    // engine 0 goes first
        end else if (!gnt_vld) begin
            if (cs0 && cs1) begin
                gnt_vld <= 1'b1;
                owner   <= !last;   // alternate on contention
            end else if (cs0) begin
                gnt_vld <= 1'b1;
                owner   <= 1'b0;
            end else if (cs1) begin
                gnt_vld <= 1'b1;
                owner   <= 1'b1;
            end
        end else if (!cs_own) begin
            // owner dropped cs, transaction over
            gnt_vld <= 1'b0;
            last    <= owner;
        end
    end

endmodule

// File: src/obj_draw.sv
// obj_draw: sprite draw engine, rom word fetch and four pixel writes per word
`timescale 1ns/1ps

module obj_draw (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    output logic                          busy,
    input  logic [obj_pkg::XPOS_W-1:0]    xpos,
    input  logic [obj_pkg::OFFSET_W-1:0]  offset,
    input  logic [obj_pkg::BANK_W-1:0]    bank,
    input  logic [obj_pkg::PRIO_W-1:0]    prio,
    input  logic [obj_pkg::PAL_W-1:0]     pal,
    input  logic                          rom_ok,
    output logic                          rom_cs,
    output logic [obj_pkg::ROM_AW-1:0]    rom_addr,
    input  logic [obj_pkg::ROM_DW-1:0]    rom_data,
    output logic                          bf_we,
    output logic [obj_pkg::XPOS_W-1:0]    bf_addr,
    output logic [obj_pkg::PIXEL_W-1:0]   bf_data
);
    import obj_pkg::*;

    localparam int LOW_W = ROM_AW - 3;  // word index inside a bank

    draw_state_e          state;
    logic [ROM_DW-1:0]    pxl;      // shift register, current pixel on top
    logic [1:0]           cnt;      // pixel index in word
    logic [PRIO_W-1:0]    prio_q;
    logic [PAL_W-1:0]     pal_q;
    logic                 last_px;  // fourth pixel of the word
    logic                 got_word;

    assign busy     = (state != D_IDLE);
    assign bf_data  = {prio_q, pal_q, pxl[ROM_DW-1 -: COLOR_W]};
    assign last_px  = (cnt == 2'd3);
    assign got_word = rom_cs && rom_ok;

    // control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= D_IDLE;
            rom_cs <= 1'b0;
            bf_we  <= 1'b0;
        end else begin
            case (state)
                D_IDLE: begin
                    if (start) begin
                        state  <= D_FETCH;
                        rom_cs <= 1'b1;     // first fetch with busy
                    end
                end
                D_FETCH: begin
                    if (got_word) begin
                        state  <= D_DRAW;
                        rom_cs <= 1'b0;     // cs drops right after ok
                        bf_we  <= 1'b1;
                    end
                end
                D_DRAW: begin
                    if (last_px) begin
                        bf_we <= 1'b0;
                        if (pxl[ROM_DW-1 -: COLOR_W] == COLOR_END) begin
                            state <= D_IDLE;    // end marker drawn, sprite done
                        end else begin
                            state  <= D_FETCH;
                            rom_cs <= 1'b1;
                        end
                    end
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    // address and pixel datapath
    always_ff @(posedge clk) begin
        case (state)
            D_IDLE: begin
                if (start) begin
                    // bank bits are swizzled into the rom map
                    rom_addr <= {bank[1:0], bank[2], offset[LOW_W-1:0]};
                    bf_addr  <= xpos;
                    prio_q   <= prio;
                    pal_q    <= pal;
                end
            end
            D_FETCH: begin
                if (got_word) begin
                    pxl <= rom_data;
                    cnt <= 2'd0;
                end
            end
            D_DRAW: begin
                pxl     <= pxl << COLOR_W;
                cnt     <= cnt + 2'd1;
                bf_addr <= bf_addr + 1'b1;  // wraps at 512
                if (last_px) begin
                    // stays inside the bank
                    rom_addr[LOW_W-1:0] <= rom_addr[LOW_W-1:0] + 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: src/obj_dispatch.sv
// obj_dispatch: four-phase descriptor input, engine selection and start pulses
`timescale 1ns/1ps

module obj_dispatch (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req,
    output logic                          ack,
    input  logic [obj_pkg::XPOS_W-1:0]    xpos,
    input  logic [obj_pkg::OFFSET_W-1:0]  offset,
    input  logic [obj_pkg::BANK_W-1:0]    bank,
    input  logic [obj_pkg::PRIO_W-1:0]    prio,
    input  logic [obj_pkg::PAL_W-1:0]     pal,
    input  logic                          busy0,
    input  logic                          busy1,
    output logic                          start0,
    output logic                          start1,
    output logic [obj_pkg::XPOS_W-1:0]    d_xpos,
    output logic [obj_pkg::OFFSET_W-1:0]  d_offset,
    output logic [obj_pkg::BANK_W-1:0]    d_bank,
    output logic [obj_pkg::PRIO_W-1:0]    d_prio,
    output logic [obj_pkg::PAL_W-1:0]     d_pal,
    output logic                          idle
);
    import obj_pkg::*;

    disp_state_e state;
    logic        pend0, pend1;  // started but busy not seen yet
    logic        free0, free1;
    logic        issue;         // descriptor accepted this cycle

    assign free0 = !busy0 && !pend0;
    assign free1 = !busy1 && !pend1;
    assign issue = (state == S_WAIT_REQ) && req && (free0 || free1);
    assign idle  = (state == S_WAIT_REQ) && !ack && !busy0 && !busy1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= S_WAIT_REQ;
            ack    <= 1'b0;
            start0 <= 1'b0;
            start1 <= 1'b0;
            pend0  <= 1'b0;
            pend1  <= 1'b0;
        end else begin
            start0 <= 1'b0;             // single cycle pulses
            start1 <= 1'b0;
            if (busy0) pend0 <= 1'b0;   // engine has taken it
            if (busy1) pend1 <= 1'b0;
            case (state)
                S_WAIT_REQ: begin
                    if (issue) begin
                        ack   <= 1'b1;  // ack and start in the same cycle
                        state <= S_WAIT_DROP;
                        if (free0) begin    // engine 0 wins a tie
                            start0 <= 1'b1;
                            pend0  <= 1'b1;
                        end else begin
                            start1 <= 1'b1;
                            pend1  <= 1'b1;
                        end
                    end
                end
                S_WAIT_DROP: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= S_WAIT_REQ;
                    end
                end
                default: state <= S_WAIT_REQ;
            endcase
        end
    end

    // registered copy of the descriptor for the engines
    always_ff @(posedge clk) begin
        if (issue) begin
            d_xpos   <= xpos;
            d_offset <= offset;
            d_bank   <= bank;
            d_prio   <= prio;
            d_pal    <= pal;
        end
    end

endmodule

// File: src/obj_pkg.sv
// obj_pkg: field widths, pixel constants and FSM state enums for the sprite line renderer
package obj_pkg;

    // descriptor fields
    localparam int XPOS_W   = 9;    // x position, also line buffer address
    localparam int OFFSET_W = 16;   // graphics offset, MSB unused (no h-flip)
    localparam int BANK_W   = 3;
    localparam int PRIO_W   = 2;
    localparam int PAL_W    = 6;

    // pixel format
    localparam int COLOR_W  = 4;
    localparam int PIXEL_W  = PRIO_W + PAL_W + COLOR_W;  // {prio, pal, colour} = 12 bits

    // graphics rom
    localparam int ROM_AW   = 18;   // {bank[1:0], bank[2], offset[14:0]}
    localparam int ROM_DW   = 16;   // four pixels, first one in the top nibble

    // line buffer depth
    localparam int LINE_LEN = 512;

    // special colours
    localparam logic [COLOR_W-1:0] COLOR_CLEAR = 4'd0;   // transparent, never stored
    localparam logic [COLOR_W-1:0] COLOR_END   = 4'd15;  // last pixel of final word

    // draw engine states
    typedef enum logic [1:0] {
        D_IDLE,     // waiting for start
        D_FETCH,    // cs high, waiting for ok
        D_DRAW      // shifting out four pixels
    } draw_state_e;

    // descriptor input states
    typedef enum logic {
        S_WAIT_REQ,     // ack low, looking for req and a free engine
        S_WAIT_DROP     // ack high until req falls
    } disp_state_e;

endpackage
